// ==== build.f ====
design/xy_pkg.sv
design/axis_if.sv
design/motion_sync.sv
design/axis_stepper.sv
design/xy_controller.sv
design/xy_positioner_top.sv
verif/xy_positioner_sva.sv
verif/tb_xy_positioner.sv

// ==== design/axis_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// controller to stepper link for one axis
interface axis_if;

   // strobes from the controller
   logic clear;   // zero target and position
   logic load;    // capture target nibble
   logic step;    // move position by one
   logic up;      // step direction, 1 counts up

   // compare status back from the axis
   logic eq;      // position == captured target
   logic lt;      // position <  captured target

   // controller side
   modport ctrl (
      output clear, load, step, up,
      input  eq, lt
   );

   // axis side
   modport axis (
      input  clear, load, step, up,
      output eq, lt
   );

endinterface

`default_nettype wire

// ==== design/axis_stepper.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_stepper (
   input  logic           clk,
   input  logic           rst_n,
   axis_if.axis           ax,
   input  xy_pkg::coord_t target,
   output xy_pkg::coord_t pos
);

   import xy_pkg::*;

   // ----------------------------------------
   // registers
   // ----------------------------------------
   coord_t target_q;   // captured target
   coord_t pos_q;      // current position

   // target capture
   // clear wins over load
   always_ff @(posedge clk) begin
      if (!rst_n || ax.clear) begin
         target_q <= '0;
      end else if (ax.load) begin
         target_q <= target;
      end
   end

   // up/down position counter
   // clear also wins over step
   always_ff @(posedge clk) begin
      if (!rst_n || ax.clear) begin
         pos_q <= '0;
      end else if (ax.step) begin
         if (ax.up) begin
            pos_q <= pos_q + coord_t'(1);
         end else begin
            pos_q <= pos_q - coord_t'(1);
         end
      end
   end

   // ----------------------------------------
   // compare
   // ----------------------------------------

   // against the captured copy, never the live input
   // so target changes during a move are ignored
   always_comb begin
      ax.eq = (pos_q == target_q);
      ax.lt = (pos_q <  target_q);
   end

   // position out to the top level nibble
   assign pos = pos_q;

endmodule

`default_nettype wire

// ==== design/motion_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module motion_sync (
   input  logic clk,
   input  logic rst_n,
   input  logic motion,
   output logic start,
   output logic motion_lvl
);

   // ----------------------------------------
   // two-flop synchronizer
   // ----------------------------------------
   logic meta_q;   // first stage, may go metastable
   logic sync_q;   // second stage, safe to use
   logic prev_q;   // sync_q one cycle late, for edge detect

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta_q <= 1'b0;
         sync_q <= 1'b0;
         prev_q <= 1'b0;
      end else begin
         meta_q <= motion;
         sync_q <= meta_q;
         prev_q <= sync_q;
      end
   end

   // ----------------------------------------
   // outputs
   // ----------------------------------------

   // level, releases the done state
   assign motion_lvl = sync_q;

   // rising edge only, so a held level gives one move
   assign start = sync_q & ~prev_q;

endmodule

`default_nettype wire

// ==== design/xy_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module xy_controller (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic motion_lvl,
   axis_if.ctrl ax_x,
   axis_if.ctrl ax_y,
   output logic busy,
   output logic done
);

   import xy_pkg::*;

   xy_state_t state_q;
   xy_state_t state_d;

   // ----------------------------------------
   // state register
   // ----------------------------------------

   // reset lands in init, which clears the axes once
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= ST_INIT;
      end else begin
         state_q <= state_d;
      end
   end

   // ----------------------------------------
   // next state
   // ----------------------------------------
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         ST_INIT: begin
            state_d = ST_IDLE;
         end
         ST_IDLE: begin
            // only a fresh edge starts a move
            if (start) begin
               state_d = ST_LOAD;
            end
         end
         ST_LOAD: begin
            state_d = ST_MOVE_X;
         end
         ST_MOVE_X: begin
            // x finished, hand over to y
            if (ax_x.eq) begin
               state_d = ST_MOVE_Y;
            end
         end
         ST_MOVE_Y: begin
            if (ax_y.eq) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            // hold result until motion released
            if (!motion_lvl) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_INIT;
         end
      endcase
   end

   // ----------------------------------------
   // axis strobes
   // ----------------------------------------

   // both axes share clear and load
   assign ax_x.clear = (state_q == ST_INIT);
   assign ax_y.clear = (state_q == ST_INIT);
   assign ax_x.load  = (state_q == ST_LOAD);
   assign ax_y.load  = (state_q == ST_LOAD);

   // step only in the active axis state, and only while not there yet
   assign ax_x.step  = (state_q == ST_MOVE_X) && !ax_x.eq;
   assign ax_y.step  = (state_q == ST_MOVE_Y) && !ax_y.eq;

   // direction follows the compare, always toward target
   assign ax_x.up    = ax_x.lt;
   assign ax_y.up    = ax_y.lt;

   // ----------------------------------------
   // status
   // ----------------------------------------

   // busy covers capture and both moves
   assign busy = (state_q == ST_LOAD)   ||
                 (state_q == ST_MOVE_X) ||
                 (state_q == ST_MOVE_Y);

   // done rises as busy falls
   assign done = (state_q == ST_DONE);

endmodule

`default_nettype wire

// ==== design/xy_pkg.sv ====
`default_nettype none

package xy_pkg;

   // ----------------------------------------
   // coordinate widths
   // ----------------------------------------

   // one axis, one nibble of the target word
   localparam int COORD_W   = 4;
   // top of the coordinate range, bounds random targets
   localparam int COORD_MAX = (1 << COORD_W) - 1;

   // position or target on a single axis
   typedef logic [COORD_W-1:0] coord_t;

   // ----------------------------------------
   // controller FSM states
   // ----------------------------------------
   typedef enum logic [2:0] {
      ST_INIT,    // one cycle, clears both axes
      ST_IDLE,    // waits for a motion edge
      ST_LOAD,    // captures both target nibbles
      ST_MOVE_X,  // steps x toward its target
      ST_MOVE_Y,  // then y
      ST_DONE     // holds until motion drops
   } xy_state_t;

endpackage

`default_nettype wire

// ==== design/xy_positioner_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module xy_positioner_top (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] target,   // x in 7:4, y in 3:0
   input  logic       motion,   // async level
   output logic [7:0] pos,      // x in 7:4, y in 3:0
   output logic       busy,
   output logic       done
);

   import xy_pkg::*;

   // ----------------------------------------
   // internal wiring
   // ----------------------------------------
   logic   start;        // one cycle pulse on motion rise
   logic   motion_lvl;   // synchronized motion level
   coord_t pos_x;
   coord_t pos_y;

   // one link per axis
   axis_if ax_x ();
   axis_if ax_y ();

   // motion input into the clock domain
   motion_sync u_sync (
      .clk        (clk),
      .rst_n      (rst_n),
      .motion     (motion),
      .start      (start),
      .motion_lvl (motion_lvl)
   );

   // sequencer
   xy_controller u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .motion_lvl (motion_lvl),
      .ax_x       (ax_x.ctrl),
      .ax_y       (ax_y.ctrl),
      .busy       (busy),
      .done       (done)
   );

   // x axis, upper nibble
   axis_stepper u_axis_x (
      .clk    (clk),
      .rst_n  (rst_n),
      .ax     (ax_x.axis),
      .target (target[7:4]),
      .pos    (pos_x)
   );

   // y axis, lower nibble
   axis_stepper u_axis_y (
      .clk    (clk),
      .rst_n  (rst_n),
      .ax     (ax_y.axis),
      .target (target[3:0]),
      .pos    (pos_y)
   );

   assign pos = {pos_x, pos_y};

endmodule

`default_nettype wire

// ==== verif/tb_xy_positioner.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_xy_positioner;

   import xy_pkg::*;

   // ----------------------------------------
   // run length
   // ----------------------------------------
   localparam int N_RANDOM    = 8;
   // random moves plus the directed ones
   localparam int N_MOVES     = N_RANDOM + 6;
   localparam int MOVE_CYCLES = 2 * COORD_MAX + 20;
   localparam int CLK_NS      = 4;
   localparam int LIMIT_NS    = N_MOVES * MOVE_CYCLES * CLK_NS;

   logic       clk;
   logic       rst_n;
   logic [7:0] target;
   logic       motion;
   logic [7:0] pos;
   logic       busy;
   logic       done;

   logic [31:0] lcg_state;
   string       test_name;
   logic [7:0]  exp_final;
   logic [7:0]  model_pos;     // where the model says the axes stand
   logic [7:0]  exp_path[$];   // model positions, one per step
   logic [7:0]  got_path[$];   // observed pos changes
   logic [7:0]  last_pos;
   event        move_end;

   xy_positioner_top u_xy_positioner_top (
      .clk    (clk),
      .rst_n  (rst_n),
      .target (target),
      .motion (motion),
      .pos    (pos),
      .busy   (busy),
      .done   (done)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   task automatic stop_with_error(input string line);
      $display("%s", line);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   initial begin
      #(LIMIT_NS);
      stop_with_error($sformatf("watchdog: run did not finish within %0d ns", LIMIT_NS));
   end

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // two in-range nibbles from the upper generator bits
   function automatic logic [7:0] rand_target();
      coord_t x;
      coord_t y;
      lcg_state = lcg_next(lcg_state);
      x = coord_t'(lcg_state[31:24] % (COORD_MAX + 1));
      lcg_state = lcg_next(lcg_state);
      y = coord_t'(lcg_state[31:24] % (COORD_MAX + 1));
      return {x, y};
   endfunction

   // reference, walks x to its target, then y
   // every intermediate position goes into exp_path
   function automatic logic [7:0] ref_move(input logic [7:0] from, input logic [7:0] to);
      coord_t x;
      coord_t y;
      x = from[7:4];
      y = from[3:0];
      exp_path.delete();
      while (x != to[7:4]) begin
         x = (x < to[7:4]) ? x + 4'd1 : x - 4'd1;
         exp_path.push_back({x, y});
      end
      while (y != to[3:0]) begin
         y = (y < to[3:0]) ? y + 4'd1 : y - 4'd1;
         exp_path.push_back({x, y});
      end
      return {x, y};
   endfunction

   // ----------------------------------------
   // checks
   // ----------------------------------------
   task automatic check_coord(input string name, input coord_t exp, input coord_t act);
      if (act !== exp) begin
         stop_with_error($sformatf("Error %s: expected %0h, actual %0h", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_with_error($sformatf("Error %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // outputs settle after the rising edge, record on the falling one
   always @(negedge clk) begin
      if (rst_n && pos !== last_pos) begin
         got_path.push_back(pos);
         last_pos = pos;
      end
   end

   // end of move, final position and step sequence against the model
   always @(move_end) begin
      check_flag({test_name, " busy"}, 1'b0, busy);
      check_flag({test_name, " done"}, 1'b1, done);
      check_coord({test_name, " x"}, exp_final[7:4], pos[7:4]);
      check_coord({test_name, " y"}, exp_final[3:0], pos[3:0]);
      if (got_path.size() != exp_path.size()) begin
         stop_with_error($sformatf("%s: saw %0d position changes, model expects %0d",
                                   test_name, got_path.size(), exp_path.size()));
      end
      foreach (exp_path[i]) begin
         check_coord($sformatf("%s step %0d x", test_name, i), exp_path[i][7:4],
                     got_path[i][7:4]);
         check_coord($sformatf("%s step %0d y", test_name, i), exp_path[i][3:0],
                     got_path[i][3:0]);
      end
   end

   // one more falling edge, fails once the move budget is spent
   task automatic tick(input string what, inout int cycles);
      @(negedge clk);
      cycles++;
      if (cycles > MOVE_CYCLES) begin
         stop_with_error($sformatf("%s: %s did not happen within %0d cycles",
                                   test_name, what, MOVE_CYCLES));
      end
   endtask

   // starts on a falling edge, returns with done high
   task automatic do_move(input string name, input logic [7:0] tgt, input bit disturb);
      int cycles;
      cycles    = 0;
      test_name = name;
      exp_final = ref_move(model_pos, tgt);
      got_path.delete();
      target = tgt;
      motion = 1'b1;
      while (!busy) begin
         tick("busy rising", cycles);
      end
      if (disturb) begin
         // capture edge still ahead, change target after it
         tick("target capture", cycles);
         target = rand_target();
         while (target == tgt) begin
            target = rand_target();
         end
      end
      while (!done) begin
         tick("done rising", cycles);
      end
      -> move_end;
      model_pos = exp_final;
   endtask

   task automatic release_motion();
      int cycles;
      cycles = 0;
      motion = 1'b0;
      while (done) begin
         tick("done falling", cycles);
      end
      check_flag({test_name, " busy after release"}, 1'b0, busy);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      logic [7:0] held;
      rst_n     = 1'b0;
      target    = 8'h00;
      motion    = 1'b0;
      last_pos  = 8'h00;
      model_pos = 8'h00;
      lcg_state = 32'h53dd_500d;
      test_name = "reset";
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      // init cycle, then idle
      repeat (2) @(negedge clk);
      check_coord("reset x", 4'd0, pos[7:4]);
      check_coord("reset y", 4'd0, pos[3:0]);
      check_flag("reset busy", 1'b0, busy);
      check_flag("reset done", 1'b0, done);

      for (int i = 0; i < N_RANDOM; i++) begin
         do_move($sformatf("random_%0d", i), rand_target(), 1'b0);
         release_motion();
      end

      // high corner first, then both axes count down
      do_move("count_down_setup", 8'hff, 1'b0);
      release_motion();
      do_move("count_down", 8'h52, 1'b0);
      release_motion();

      do_move("capture_isolation", rand_target(), 1'b1);
      release_motion();

      // nonzero end point, so the restart proves it starts from here
      held = rand_target() | 8'h11;
      do_move("edge_hold", held, 1'b0);
      repeat (10) begin
         @(negedge clk);
         check_flag("edge_hold busy", 1'b0, busy);
         check_flag("edge_hold done", 1'b1, done);
         check_coord("edge_hold x", held[7:4], pos[7:4]);
         check_coord("edge_hold y", held[3:0], pos[3:0]);
      end
      release_motion();
      // back in idle, position still held
      check_coord("edge_release x", held[7:4], pos[7:4]);
      check_coord("edge_release y", held[3:0], pos[3:0]);
      do_move("edge_restart", rand_target(), 1'b0);
      release_motion();

      do_move("zero_length", model_pos, 1'b0);
      release_motion();

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/xy_positioner_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module xy_positioner_sva (
   input logic       clk,
   input logic       rst_n,
   input logic [7:0] target,
   input logic [7:0] pos,
   input logic       busy,
   input logic       done
);

   import xy_pkg::*;

   coord_t x_final;   // x target captured at the start of a move
   logic   busy_q;

   // the load edge is the first busy cycle, so sample target there
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         x_final <= '0;
         busy_q  <= 1'b0;
      end else begin
         busy_q <= busy;
         if (busy && !busy_q) begin
            x_final <= target[7:4];
         end
      end
   end

   // same value, or one count up or down
   function automatic logic one_step(input coord_t now, input coord_t was);
      return (now == was) ||
             (now == coord_t'(was + 1'b1)) ||
             (now == coord_t'(was - 1'b1));
   endfunction

   // ----------------------------------------
   // properties
   // ----------------------------------------
   a_step_x: assert property (@(posedge clk) disable iff (!rst_n)
      one_step(pos[7:4], $past(pos[7:4])))
      else $error("x position moved by more than one count");

   a_step_y: assert property (@(posedge clk) disable iff (!rst_n)
      one_step(pos[3:0], $past(pos[3:0])))
      else $error("y position moved by more than one count");

   // y only moves once x has arrived
   a_x_before_y: assert property (@(posedge clk) disable iff (!rst_n)
      $changed(pos[3:0]) |-> (pos[7:4] == x_final))
      else $error("y position moved before x reached its target");

   a_done_stable: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> $stable(pos))
      else $error("position changed while done was high");

   a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
      !(busy && done))
      else $error("busy and done high in the same cycle");

endmodule

bind xy_positioner_top xy_positioner_sva u_sva (
   .clk    (clk),
   .rst_n  (rst_n),
   .target (target),
   .pos    (pos),
   .busy   (busy),
   .done   (done)
);

`default_nettype wire
